// File: Makefile
# Verilator build and run of the SIMD ALU testbench

TOP       ?= simd_alu_tb
FLIST     ?= tb.f
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, pass only if the run reports sim passed"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: TOP FLIST VERILATOR OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)

// File: logic/simd_alu_config.svh
////////////////////
// Word and lane geometry of the SIMD unit
// Only a 32-bit word of four byte lanes is supported
////////////////////

`ifndef SIMD_ALU_CONFIG_SVH
`define SIMD_ALU_CONFIG_SVH

// Full word width
`define SIMD_XLEN 32

// Narrowest lane, one byte
`define SIMD_LANE_W 8

// Byte lanes per word
`define SIMD_LANES 4

`endif

// File: logic/simd_alu_top.sv
////////////////////
// Packed SIMD ALU with one registered output stage
// Result is valid one cycle after valid_i, no back-pressure
////////////////////

`timescale 1ns/1ps
`default_nettype none

module simd_alu_top
  import simd_op_pkg::*;
  import simd_lane_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     valid_i,
  input  simd_op_e op_i,
  input  word_t    operand_a_i,
  input  word_t    operand_b_i,
  output word_t    result_o,
  output logic     set_ov_o,
  output logic     valid_o
);

  elem_width_e width;
  logic        is_signed;
  logic        is_sub;
  arith_mode_e arith_mode;
  cmp_kind_e   cmp_kind;
  result_sel_e result_sel;
  word_t       sum_w;
  word_t       diff_w;
  lane_mask_t  ovf;
  word_t       cmp_w;
  word_t       minmax_w;
  word_t       count_w;
  word_t       result_d;

  simd_op_decoder u_decoder (
    .op_i         (op_i),
    .width_o      (width),
    .is_signed_o  (is_signed),
    .is_sub_o     (is_sub),
    .arith_mode_o (arith_mode),
    .cmp_kind_o   (cmp_kind),
    .result_sel_o (result_sel)
  );

  simd_lane_adder u_adder (
    .a_i         (operand_a_i),
    .b_i         (operand_b_i),
    .width_i     (width),
    .is_signed_i (is_signed),
    .is_sub_i    (is_sub),
    .mode_i      (arith_mode),
    .sum_o       (sum_w),
    .diff_o      (diff_w),
    .ovf_o       (ovf)
  );

  // Compare works on the adder's A minus B
  simd_compare u_compare (
    .a_i         (operand_a_i),
    .b_i         (operand_b_i),
    .diff_i      (diff_w),
    .width_i     (width),
    .is_signed_i (is_signed),
    .kind_i      (cmp_kind),
    .cmp_o       (cmp_w),
    .minmax_o    (minmax_w)
  );

  simd_bit_count u_bit_count (
    .a_i     (operand_a_i),
    .width_i (width),
    .clrs_i  (result_sel == CLRS),
    .count_o (count_w)
  );

  always_comb begin
    case (result_sel)
      ADDER:     result_d = sum_w;
      CMP:       result_d = cmp_w;
      MINMAX:    result_d = minmax_w;
      CLZ, CLRS: result_d = count_w;
      default:   result_d = '0;
    endcase
  end

  ////////////////////
  // Output stage
  ////////////////////
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      result_o <= '0;
      set_ov_o <= 1'b0;
      valid_o  <= 1'b0;
    end else begin
      // idle cycles load zeros
      result_o <= valid_i ? result_d : '0;
      set_ov_o <= valid_i & (|ovf);
      valid_o  <= valid_i;
    end
  end

endmodule

`default_nettype wire

// File: logic/simd_bit_count.sv
////////////////////
// Leading zero and leading redundant sign counts
// CLRS never counts the sign bit itself
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "simd_alu_config.svh"

module simd_bit_count
  import simd_op_pkg::*;
  import simd_lane_pkg::*;
(
  input  word_t       a_i,
  input  elem_width_e width_i,
  input  logic        clrs_i,
  output word_t       count_o
);

  localparam int W = `SIMD_LANE_W;

  lane_mask_t top;
  lane_mask_t msb;
  lane_mask_t sgn;
  word_t      mark;
  logic [3:0] cnt_b [`SIMD_LANES];
  logic [4:0] cnt_h [2];
  logic [5:0] cnt_w;

  assign top = lane_top(width_i);

  always_comb begin
    for (int k = 0; k < `SIMD_LANES; k++) begin
      msb[k] = a_i[W*k+W-1];
    end
  end

  assign sgn = lane_spread(msb, width_i) & {`SIMD_LANES{clrs_i}};

  ////////////////////
  // Prefix chain from each element top
  ////////////////////
  always_comb begin
    logic run;
    logic at_top;
    run = 1'b1;
    for (int i = `SIMD_XLEN-1; i >= 0; i--) begin
      at_top = (i % W == W-1) && top[i/W];
      if (at_top) begin
        run = 1'b1;
      end
      run     = run & ~(a_i[i] ^ sgn[i/W]);
      mark[i] = run & ~(clrs_i & at_top);
    end
  end

  // Adder tree, bytes then halves then word
  always_comb begin
    for (int k = 0; k < `SIMD_LANES; k++) begin
      cnt_b[k] = '0;
      for (int j = 0; j < W; j++) begin
        cnt_b[k] = cnt_b[k] + 4'(mark[W*k+j]);
      end
    end
  end

  assign cnt_h[0] = 5'(cnt_b[0]) + 5'(cnt_b[1]);
  assign cnt_h[1] = 5'(cnt_b[2]) + 5'(cnt_b[3]);
  assign cnt_w    = 6'(cnt_h[0]) + 6'(cnt_h[1]);

  always_comb begin
    case (width_i)
      W8:      count_o = {4'h0, cnt_b[3], 4'h0, cnt_b[2], 4'h0, cnt_b[1], 4'h0, cnt_b[0]};
      W16:     count_o = {11'h0, cnt_h[1], 11'h0, cnt_h[0]};
      default: count_o = {26'h0, cnt_w};
    endcase
  end

endmodule

`default_nettype wire

// File: logic/simd_compare.sv
////////////////////
// Lane compares and min/max select
// diff_i must be A minus B at the same element width
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "simd_alu_config.svh"

module simd_compare
  import simd_op_pkg::*;
  import simd_lane_pkg::*;
(
  input  word_t       a_i,
  input  word_t       b_i,
  input  word_t       diff_i,
  input  elem_width_e width_i,
  input  logic        is_signed_i,
  input  cmp_kind_e   kind_i,
  output word_t       cmp_o,
  output word_t       minmax_o
);

  localparam int W = `SIMD_LANE_W;

  lane_mask_t eq_b;
  lane_mask_t lt_b;
  lane_mask_t eq_e;
  lane_mask_t lt_e;
  lane_mask_t hit;

  always_comb begin
    logic a_s;
    logic b_s;
    for (int k = 0; k < `SIMD_LANES; k++) begin
      a_s     = a_i[W*k+W-1];
      b_s     = b_i[W*k+W-1];
      eq_b[k] = (diff_i[W*k +: W] == '0);
      // Top bits differ so the difference may have wrapped
      lt_b[k] = (a_s == b_s) ? diff_i[W*k+W-1] : (is_signed_i ? a_s : b_s);
    end
  end

  // Equal needs every byte of the element to be zero
  always_comb begin
    case (width_i)
      W8:      eq_e = eq_b;
      W16:     eq_e = {{2{&eq_b[3:2]}}, {2{&eq_b[1:0]}}};
      default: eq_e = {4{&eq_b}};
    endcase
  end

  assign lt_e = lane_spread(lt_b, width_i);

  always_comb begin
    case (kind_i)
      LT, MIN: hit = lt_e;
      LE:      hit = lt_e | eq_e;
      MAX:     hit = ~(lt_e | eq_e);
      default: hit = eq_e;
    endcase
  end

  always_comb begin
    for (int k = 0; k < `SIMD_LANES; k++) begin
      cmp_o[W*k +: W]    = {W{hit[k]}};
      minmax_o[W*k +: W] = hit[k] ? a_i[W*k +: W] : b_i[W*k +: W];
    end
  end

endmodule

`default_nettype wire

// File: logic/simd_lane_adder.sv
////////////////////
// Byte-sliced adder with carry cut at element edges
// Gives wrapping, halving and saturating results
// ovf_o is only set in SAT mode
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "simd_alu_config.svh"

module simd_lane_adder
  import simd_op_pkg::*;
  import simd_lane_pkg::*;
(
  input  word_t       a_i,
  input  word_t       b_i,
  input  elem_width_e width_i,
  input  logic        is_signed_i,
  input  logic        is_sub_i,
  input  arith_mode_e mode_i,
  output word_t       sum_o,
  output word_t       diff_o,
  output lane_mask_t  ovf_o
);

  localparam int W = `SIMD_LANE_W;

  lane_mask_t top;
  lane_mask_t ext_b;
  lane_mask_t ovf_b;
  lane_mask_t ext_e;
  lane_mask_t sat_e;
  word_t      b_inv;
  word_t      wrap_w;
  word_t      half_w;
  word_t      sat_w;
  logic [W:0] raw [`SIMD_LANES];

  assign top   = lane_top(width_i);
  assign b_inv = is_sub_i ? ~b_i : b_i;

  ////////////////////
  // Byte adders
  ////////////////////
  always_comb begin
    logic carry;
    carry = is_sub_i;
    for (int k = 0; k < `SIMD_LANES; k++) begin
      raw[k] = {1'b0, a_i[W*k +: W]} + {1'b0, b_inv[W*k +: W]} + {{W{1'b0}}, carry};
      // Next byte starts a new element when this one is a top byte
      carry  = top[k] ? is_sub_i : raw[k][W];
      // Extra bit of the exact result, used only at top bytes
      ext_b[k] = raw[k][W] ^
                 (is_signed_i ? (a_i[W*k+W-1] ^ b_inv[W*k+W-1]) : is_sub_i);
      ovf_b[k] = ext_b[k] ^ (is_signed_i & raw[k][W-1]);
      wrap_w[W*k +: W] = raw[k][W-1:0];
    end
  end

  assign ext_e = lane_spread(ext_b, width_i);
  assign sat_e = lane_spread(ovf_b, width_i);

  ////////////////////
  // Halving and clamping
  ////////////////////
  always_comb begin
    logic fill;
    half_w = wrap_w >> 1;
    for (int k = 0; k < `SIMD_LANES; k++) begin
      if (top[k]) begin
        half_w[W*k+W-1] = ext_b[k];
      end
      // Signed clamps toward the sign, unsigned sub floors at zero
      fill = is_signed_i ? ~ext_e[k] : ~is_sub_i;
      sat_w[W*k +: W] = sat_e[k] ? {fill ^ (is_signed_i & top[k]), {(W-1){fill}}}
                                 : wrap_w[W*k +: W];
    end
  end

  always_comb begin
    case (mode_i)
      HALVE:   sum_o = half_w;
      SAT:     sum_o = sat_w;
      default: sum_o = wrap_w;
    endcase
  end

  assign diff_o = wrap_w;
  assign ovf_o  = (mode_i == SAT) ? sat_e : '0;

endmodule

`default_nettype wire

// File: logic/simd_lane_pkg.sv
////////////////////
// Word, lane mask and lane helper functions
// Needs simd_op_pkg compiled first
////////////////////

`default_nettype none

`include "simd_alu_config.svh"

package simd_lane_pkg;
  import simd_op_pkg::*;

  typedef logic [`SIMD_XLEN-1:0]  word_t;
  typedef logic [`SIMD_LANES-1:0] lane_mask_t;

  // Marks the byte that holds each element's top bit
  function automatic lane_mask_t lane_top(elem_width_e w);
    case (w)
      W8:      return 4'b1111;
      W16:     return 4'b1010;
      default: return 4'b1000;
    endcase
  endfunction

  // Copies the top byte's bit over the whole element
  function automatic lane_mask_t lane_spread(lane_mask_t m, elem_width_e w);
    case (w)
      W8:      return m;
      W16:     return {{2{m[3]}}, {2{m[1]}}};
      default: return {4{m[3]}};
    endcase
  endfunction

endpackage

`default_nettype wire

// File: logic/simd_op_decoder.sv
////////////////////
// Operation decode, purely combinational
// Compares and min/max force a subtract
////////////////////

`timescale 1ns/1ps
`default_nettype none

module simd_op_decoder
  import simd_op_pkg::*;
(
  input  simd_op_e    op_i,
  output elem_width_e width_o,
  output logic        is_signed_o,
  output logic        is_sub_o,
  output arith_mode_e arith_mode_o,
  output cmp_kind_e   cmp_kind_o,
  output result_sel_e result_sel_o
);

  typedef struct packed {
    logic        sgn;
    logic        sub;
    arith_mode_e mode;
    cmp_kind_e   kind;
    result_sel_e sel;
  } ctl_t;

  ctl_t ctl;

  always_comb begin
    // Columns: signed, subtract, mode, compare kind, result block
    case (op_i)
      ADD8, ADD16:               ctl = '{1'b0, 1'b0, WRAP,  EQ,  ADDER};
      SUB8, SUB16:               ctl = '{1'b0, 1'b1, WRAP,  EQ,  ADDER};
      RADD8, RADD16, RADDW:      ctl = '{1'b1, 1'b0, HALVE, EQ,  ADDER};
      URADD8, URADD16, URADDW:   ctl = '{1'b0, 1'b0, HALVE, EQ,  ADDER};
      RSUB8, RSUB16, RSUBW:      ctl = '{1'b1, 1'b1, HALVE, EQ,  ADDER};
      URSUB8, URSUB16, URSUBW:   ctl = '{1'b0, 1'b1, HALVE, EQ,  ADDER};
      KADD8, KADD16, KADDW:      ctl = '{1'b1, 1'b0, SAT,   EQ,  ADDER};
      UKADD8, UKADD16, UKADDW:   ctl = '{1'b0, 1'b0, SAT,   EQ,  ADDER};
      KSUB8, KSUB16, KSUBW:      ctl = '{1'b1, 1'b1, SAT,   EQ,  ADDER};
      UKSUB8, UKSUB16, UKSUBW:   ctl = '{1'b0, 1'b1, SAT,   EQ,  ADDER};
      CMPEQ8, CMPEQ16:           ctl = '{1'b0, 1'b1, WRAP,  EQ,  CMP};
      SCMPLT8, SCMPLT16:         ctl = '{1'b1, 1'b1, WRAP,  LT,  CMP};
      SCMPLE8, SCMPLE16:         ctl = '{1'b1, 1'b1, WRAP,  LE,  CMP};
      UCMPLT8, UCMPLT16:         ctl = '{1'b0, 1'b1, WRAP,  LT,  CMP};
      UCMPLE8, UCMPLE16:         ctl = '{1'b0, 1'b1, WRAP,  LE,  CMP};
      SMIN8, SMIN16:             ctl = '{1'b1, 1'b1, WRAP,  MIN, MINMAX};
      SMAX8, SMAX16:             ctl = '{1'b1, 1'b1, WRAP,  MAX, MINMAX};
      UMIN8, UMIN16:             ctl = '{1'b0, 1'b1, WRAP,  MIN, MINMAX};
      UMAX8, UMAX16:             ctl = '{1'b0, 1'b1, WRAP,  MAX, MINMAX};
      CLZ8, CLZ16, CLZ32:        ctl = '{1'b0, 1'b0, WRAP,  EQ,  CLZ};
      CLRS8, CLRS16, CLRS32:     ctl = '{1'b0, 1'b0, WRAP,  EQ,  CLRS};
      default:                   ctl = '{1'b0, 1'b0, WRAP,  EQ,  NONE};
    endcase

    // Element width, 32-bit unless named otherwise
    case (op_i)
      ADD8, SUB8, RADD8, URADD8, RSUB8, URSUB8, KADD8, UKADD8, KSUB8, UKSUB8,
      CMPEQ8, SCMPLT8, SCMPLE8, UCMPLT8, UCMPLE8, SMIN8, SMAX8, UMIN8, UMAX8,
      CLZ8, CLRS8:
        width_o = W8;
      ADD16, SUB16, RADD16, URADD16, RSUB16, URSUB16, KADD16, UKADD16, KSUB16, UKSUB16,
      CMPEQ16, SCMPLT16, SCMPLE16, UCMPLT16, UCMPLE16, SMIN16, SMAX16, UMIN16, UMAX16,
      CLZ16, CLRS16:
        width_o = W16;
      default:
        width_o = W32;
    endcase
  end

  assign is_signed_o  = ctl.sgn;
  assign is_sub_o     = ctl.sub;
  assign arith_mode_o = ctl.mode;
  assign cmp_kind_o   = ctl.kind;
  assign result_sel_o = ctl.sel;

endmodule

`default_nettype wire

// File: logic/simd_op_pkg.sv
////////////////////
// Operation codes and decoded control types
// NOP and any code not listed give a zero result
////////////////////

`default_nettype none

package simd_op_pkg;

  typedef enum logic [5:0] {
    NOP = 6'h00,
    // Wrapping add and subtract
    ADD8, ADD16, SUB8, SUB16,
    // Halving
    RADD8, RADD16, RADDW, URADD8, URADD16, URADDW,
    RSUB8, RSUB16, RSUBW, URSUB8, URSUB16, URSUBW,
    // Saturating
    KADD8, KADD16, KADDW, UKADD8, UKADD16, UKADDW,
    KSUB8, KSUB16, KSUBW, UKSUB8, UKSUB16, UKSUBW,
    // Lane compares
    CMPEQ8, CMPEQ16, SCMPLT8, SCMPLT16, SCMPLE8, SCMPLE16,
    UCMPLT8, UCMPLT16, UCMPLE8, UCMPLE16,
    // Min and max
    SMIN8, SMIN16, SMAX8, SMAX16, UMIN8, UMIN16, UMAX8, UMAX16,
    // Bit counts
    CLZ8, CLZ16, CLZ32, CLRS8, CLRS16, CLRS32
  } simd_op_e;

  typedef enum logic [1:0] {W8, W16, W32} elem_width_e;

  typedef enum logic [1:0] {WRAP, HALVE, SAT} arith_mode_e;

  typedef enum logic [2:0] {ADDER, CMP, MINMAX, CLZ, CLRS, NONE} result_sel_e;

  // MIN and MAX reuse the less-than path
  typedef enum logic [2:0] {EQ, LT, LE, MIN, MAX} cmp_kind_e;

endpackage

`default_nettype wire

// File: tb.f
+incdir+logic
logic/simd_op_pkg.sv
logic/simd_lane_pkg.sv
logic/simd_op_decoder.sv
logic/simd_lane_adder.sv
logic/simd_compare.sv
logic/simd_bit_count.sv
logic/simd_alu_top.sv
verif/simd_alu_tb.sv

// File: verif/simd_alu_tb.sv
////////////////////
// Directed table test of the SIMD ALU top level
// One row per operation, checked one cycle after issue
// Each row is followed by an idle cycle that must read zero
////////////////////

`timescale 1ns/1ps
`default_nettype none

module simd_alu_tb
  import simd_op_pkg::*;
  import simd_lane_pkg::*;
;

  localparam int NUM_ROWS = 20;
  // Reset, two cycles per row, then margin
  localparam int CYCLE_LIMIT = 16 + 2 * NUM_ROWS + 50;

  typedef struct {
    string    name;
    simd_op_e op;
    word_t    a;
    word_t    b;
    word_t    exp;
    logic     ov;
  } row_t;

  logic     clk_i;
  logic     arst_n_i;
  logic     valid_i;
  simd_op_e op_i;
  word_t    operand_a_i;
  word_t    operand_b_i;
  word_t    result_o;
  logic     set_ov_o;
  logic     valid_o;

  row_t rows [NUM_ROWS];
  int   errors;
  int   passed;
  int   failed;
  int   cycle_count;
  logic test_bad;

  simd_alu_top dut (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .valid_i     (valid_i),
    .op_i        (op_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .result_o    (result_o),
    .set_ov_o    (set_ov_o),
    .valid_o     (valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Expected values worked out by hand per lane
  task automatic load_table();
    rows[0]  = '{"add8_wrap",      ADD8,    32'h010203FF, 32'h01010101, 32'h02030400, 1'b0};
    rows[1]  = '{"sub8_wrap",      SUB8,    32'h00050010, 32'h01010001, 32'hFF04000F, 1'b0};
    rows[2]  = '{"add16_carry",    ADD16,   32'h000100FF, 32'h00010001, 32'h00020100, 1'b0};
    rows[3]  = '{"kadd8_clamp",    KADD8,   32'h7F800102, 32'h0180FF01, 32'h7F800003, 1'b1};
    rows[4]  = '{"ksub16_clamp",   KSUB16,  32'h7FF08000, 32'hFF000001, 32'h7FFF8000, 1'b1};
    rows[5]  = '{"uksubw_floor",   UKSUBW,  32'h00000005, 32'h00000010, 32'h00000000, 1'b1};
    rows[6]  = '{"kadd16_inrange", KADD16,  32'h00010002, 32'h00030004, 32'h00040006, 1'b0};
    rows[7]  = '{"radd8_halve",    RADD8,   32'h7F80FF03, 32'h7F8001FF, 32'h7F800001, 1'b0};
    rows[8]  = '{"uradd8_halve",   URADD8,  32'hFF000102, 32'hFF000304, 32'hFF000203, 1'b0};
    rows[9]  = '{"ursub16_halve",  URSUB16, 32'h00100000, 32'h00040002, 32'h0006FFFF, 1'b0};
    rows[10] = '{"cmpeq16",        CMPEQ16, 32'h12345678, 32'h12345679, 32'hFFFF0000, 1'b0};
    rows[11] = '{"scmplt8",        SCMPLT8, 32'h80010505, 32'h01800506, 32'hFF0000FF, 1'b0};
    rows[12] = '{"ucmple8",        UCMPLE8, 32'h80010505, 32'h01800506, 32'h00FFFFFF, 1'b0};
    rows[13] = '{"ucmplt8",        UCMPLT8, 32'h80010505, 32'h01800506, 32'h00FF00FF, 1'b0};
    rows[14] = '{"smin8",          SMIN8,   32'h80017F05, 32'h0180FF06, 32'h8080FF05, 1'b0};
    rows[15] = '{"umax16",         UMAX16,  32'h80000001, 32'h7FFF0002, 32'h80000002, 1'b0};
    rows[16] = '{"clz8",           CLZ8,    32'h00010080, 32'h00000000, 32'h08070800, 1'b0};
    rows[17] = '{"clz32",          CLZ32,   32'h00000001, 32'h00000000, 32'h0000001F, 1'b0};
    rows[18] = '{"clrs16",         CLRS16,  32'hFFFF0001, 32'h00000000, 32'h000F000E, 1'b0};
    rows[19] = '{"nop_zero",       NOP,     32'hFFFFFFFF, 32'h12345678, 32'h00000000, 1'b0};
  endtask

  task automatic check_value(input string name, input string what,
                             input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("** Error: %s %s expected %h actual %h", name, what, expected, actual);
      errors++;
      test_bad = 1'b1;
    end
  endtask

  ////////////////////
  // Run limit
  ////////////////////
  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Run stopped after %0d cycles without reaching the end", cycle_count);
      $display("sim failed");
      $finish;
    end
  end

  initial begin
    errors      = 0;
    passed      = 0;
    failed      = 0;
    test_bad    = 1'b0;
    arst_n_i    <= 1'b0;
    valid_i     <= 1'b0;
    op_i        <= NOP;
    operand_a_i <= '0;
    operand_b_i <= '0;
    load_table();

    repeat (15) @(posedge clk_i);

    // Outputs hold their reset values while arst_n_i is low
    @(negedge clk_i);
    check_value("reset", "result", '0, result_o);
    check_value("reset", "flag", '0, word_t'(set_ov_o));
    check_value("reset", "valid", '0, word_t'(valid_o));
    if (test_bad) begin
      failed++;
      $display("%-16s FAIL", "reset");
    end else begin
      passed++;
      $display("%-16s ok", "reset");
    end

    @(posedge clk_i);
    arst_n_i <= 1'b1;

    for (int i = 0; i < NUM_ROWS; i++) begin
      test_bad = 1'b0;
      @(posedge clk_i);
      valid_i     <= 1'b1;
      op_i        <= rows[i].op;
      operand_a_i <= rows[i].a;
      operand_b_i <= rows[i].b;

      // Previous cycle was idle, or reset for the first row
      @(negedge clk_i);
      if (valid_o !== 1'b0) begin
        $display("%s: valid_o was high in the idle cycle before issue", rows[i].name);
        errors++;
        test_bad = 1'b1;
      end
      check_value(rows[i].name, "idle result", '0, result_o);
      check_value(rows[i].name, "idle flag", '0, word_t'(set_ov_o));

      @(posedge clk_i);
      valid_i <= 1'b0;

      @(negedge clk_i);
      if (valid_o !== 1'b1) begin
        $display("%s: valid_o did not rise one cycle after issue", rows[i].name);
        errors++;
        test_bad = 1'b1;
      end
      check_value(rows[i].name, "result", rows[i].exp, result_o);
      check_value(rows[i].name, "flag", word_t'(rows[i].ov), word_t'(set_ov_o));

      if (test_bad) begin
        failed++;
        $display("%-16s FAIL", rows[i].name);
      end else begin
        passed++;
        $display("%-16s ok", rows[i].name);
      end
    end

    $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
             NUM_ROWS + 1, passed, failed, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
